//--- list.f
rtl/pid_pkg.sv
rtl/oversample_filter.sv
rtl/pid_core.sv
rtl/router.sv
rtl/output_preprocessor.sv
rtl/dac_instr_queue.sv
rtl/pid_controller.sv
tests/dac_checker.sv
tests/tb_pid_controller.sv

//--- rtl/dac_instr_queue.sv
`timescale 1ns/1ps
`default_nettype none

// n_out is at least 2 so the channel field has a bit
module dac_instr_queue #(
	parameter int n_out = 4
) (
	input  logic                            clk50,
	input  logic                            rst_n,
	input  logic [n_out-1:0]                in_valid,
	input  logic [pid_pkg::w_dac-1:0]       in_data [n_out],
	output logic                            dac_valid,
	input  logic                            dac_ready,
	output logic [$clog2(n_out)-1:0]        dac_chan,
	output logic [pid_pkg::w_dac-1:0]       dac_data
);

	localparam int w_ch = $clog2(n_out);

	logic [n_out-1:0]          pending;	// channel has a value not yet handed out
	logic [pid_pkg::w_dac-1:0] val [n_out];	// newest value per channel
	logic [w_ch-1:0]           rr_ptr;	// first channel to look at
	logic [w_ch-1:0]           pick;
	logic                      found;
	logic                      load;	// output register takes pick this cycle
	logic [n_out-1:0]          clr;

	////////////////////////////////////////////////////////////
	// round-robin search
	////////////////////////////////////////////////////////////

	always_comb begin
		found = 1'b0;
		pick  = rr_ptr;
		// walk from the far end so the nearest pending channel wins
		for (int k = n_out - 1; k >= 0; k--) begin
			if (pending[(int'(rr_ptr) + k) % n_out]) begin
				found = 1'b1;
				pick  = w_ch'((int'(rr_ptr) + k) % n_out);
			end
		end
		load = found && (!dac_valid || dac_ready);	// free, or emptied by this transfer
		clr  = '0;
		if (load)
			clr[pick] = 1'b1;
	end

	always_ff @(posedge clk50 or negedge rst_n) begin
		if (!rst_n) begin
			pending   <= '0;
			rr_ptr    <= '0;
			dac_valid <= 1'b0;
		end else begin
			pending <= (pending & ~clr) | in_valid;	// a fresh arrival keeps the flag
			if (load) begin
				dac_valid <= 1'b1;
				rr_ptr    <= w_ch'((int'(pick) + 1) % n_out);
			end else if (dac_ready) begin
				dac_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk50) begin
		for (int c = 0; c < n_out; c++)
			if (in_valid[c])
				val[c] <= in_data[c];	// overwrite, only the newest matters
		if (load) begin
			dac_chan <= pick;
			dac_data <= val[pick];		// held until dac_ready
		end
	end

endmodule

`default_nettype wire

//--- rtl/output_preprocessor.sv
`timescale 1ns/1ps
`default_nettype none

module output_preprocessor (
	input  logic                              clk50,
	input  logic                              rst_n,
	input  logic                              in_valid,
	input  logic signed [pid_pkg::w_pid-1:0]  in_data,
	input  logic                              lock_en,		// 0 parks the output at out_init
	input  logic        [pid_pkg::w_dac-1:0]  out_min,
	input  logic        [pid_pkg::w_dac-1:0]  out_max,
	input  logic        [pid_pkg::w_dac-1:0]  out_init,	// offset and hold value
	input  logic        [pid_pkg::w_mult-1:0] multiplier,
	output logic                              out_valid,
	output logic        [pid_pkg::w_dac-1:0]  out_data
);

	localparam int w_sum = pid_pkg::w_pid + pid_pkg::w_mult + 2;	// product plus offset, signed

	logic signed [w_sum-1:0] init_s;
	logic signed [w_sum-1:0] mult_s;
	logic signed [w_sum-1:0] lim_lo;
	logic signed [w_sum-1:0] lim_hi;
	logic signed [w_sum-1:0] scaled;

	always_comb begin
		init_s = w_sum'(out_init);		// zero extended
		mult_s = w_sum'(multiplier);		// gain is never negative
		lim_lo = w_sum'(out_min);
		lim_hi = w_sum'(out_max);
		scaled = init_s + w_sum'(in_data) * mult_s;
	end

	always_ff @(posedge clk50 or negedge rst_n) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;	// one update per input, locked or not
	end

	always_ff @(posedge clk50) begin
		if (in_valid) begin
			if (!lock_en)
				out_data <= out_init;
			else if (scaled < lim_lo)
				out_data <= out_min;
			else if (scaled > lim_hi)
				out_data <= out_max;
			else
				out_data <= scaled[pid_pkg::w_dac-1:0];
		end
	end

endmodule

`default_nettype wire

//--- rtl/oversample_filter.sv
`timescale 1ns/1ps
`default_nettype none

module oversample_filter (
	input  logic                                clk50,
	input  logic                                rst_n,
	input  logic                                in_valid,	// strobe for this channel only
	input  logic signed [pid_pkg::w_sample-1:0] in_data,
	input  logic        [pid_pkg::w_osm-1:0]    osm,		// average over 2^osm samples
	input  logic                                cfg_update,
	output logic                                out_valid,
	output logic signed [pid_pkg::w_pid-1:0]    out_data
);

	localparam int w_sum = pid_pkg::w_sample + 4;	// headroom for 16 samples
	localparam logic signed [w_sum-1:0] sat_hi = w_sum'(2**(pid_pkg::w_pid-1) - 1);
	localparam logic signed [w_sum-1:0] sat_lo = w_sum'(-(2**(pid_pkg::w_pid-1)));

	logic        [pid_pkg::w_osm-1:0] osm_q;	// mode in force since last cfg_update
	logic        [4:0]                cnt;		// samples taken in the open group
	logic signed [w_sum-1:0]          sum;
	logic signed [w_sum-1:0]          sum_nxt;
	logic signed [w_sum-1:0]          avg;
	logic                             last;		// current sample closes the group

	always_comb begin
		sum_nxt = sum + w_sum'(in_data);	// sign extended
		avg     = sum_nxt >>> osm_q;		// divide by 2^osm, rounds toward -inf
		last    = (cnt + 5'd1) == (5'd1 << osm_q);
	end

	always_ff @(posedge clk50 or negedge rst_n) begin
		if (!rst_n) begin
			osm_q     <= '0;
			cnt       <= '0;
			sum       <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			if (cfg_update) begin
				// new mode, drop the partial group
				osm_q <= osm;
				cnt   <= '0;
				sum   <= '0;
			end else if (in_valid) begin
				if (last) begin
					cnt       <= '0;
					sum       <= '0;
					out_valid <= 1'b1;
				end else begin
					cnt <= cnt + 5'd1;
					sum <= sum_nxt;
				end
			end
		end
	end

	// average, clipped to the pid input range
	always_ff @(posedge clk50) begin
		if (in_valid && last) begin
			if (avg > sat_hi)
				out_data <= sat_hi[pid_pkg::w_pid-1:0];
			else if (avg < sat_lo)
				out_data <= sat_lo[pid_pkg::w_pid-1:0];
			else
				out_data <= avg[pid_pkg::w_pid-1:0];
		end
	end

endmodule

`default_nettype wire

//--- rtl/pid_controller.sv
`timescale 1ns/1ps
`default_nettype none

module pid_controller #(
	parameter int n_in  = 4,	// adc / pid channels
	parameter int n_out = 4	// dac channels
) (
	input  logic                              clk50,
	input  logic                              rst_n,
	// parallel sample bus, one word per cycle at most
	input  logic                              sample_valid,
	input  logic        [$clog2(n_in)-1:0]    sample_chan,
	input  logic signed [pid_pkg::w_sample-1:0] sample_data,
	// configuration, taken in on cfg_update
	input  logic                              cfg_update,
	input  logic        [pid_pkg::w_osm-1:0]  osm,
	input  logic signed [pid_pkg::w_coef-1:0] setpoint,
	input  logic signed [pid_pkg::w_coef-1:0] p_coef,
	input  logic signed [pid_pkg::w_coef-1:0] i_coef,
	input  logic signed [pid_pkg::w_coef-1:0] d_coef,
	input  logic        [$clog2(n_in)-1:0]    rtr_sel [n_out],
	input  logic        [n_out-1:0]           lock_en,
	input  logic        [pid_pkg::w_dac-1:0]  out_min,
	input  logic        [pid_pkg::w_dac-1:0]  out_max,
	input  logic        [pid_pkg::w_dac-1:0]  out_init,
	input  logic        [pid_pkg::w_mult-1:0] multiplier,
	// dac update port
	output logic                              dac_valid,
	input  logic                              dac_ready,
	output logic        [$clog2(n_out)-1:0]   dac_chan,
	output logic        [pid_pkg::w_dac-1:0]  dac_data
);

	localparam int w_in_ch = $clog2(n_in);

	logic        [n_in-1:0]           smp_valid;	// sample strobe per filter
	logic        [n_in-1:0]           osf_valid;
	logic signed [pid_pkg::w_pid-1:0] osf_data [n_in];
	logic        [n_in-1:0]           pid_valid;
	logic signed [pid_pkg::w_pid-1:0] pid_data [n_in];
	logic        [n_out-1:0]          rtr_valid;
	logic signed [pid_pkg::w_pid-1:0] rtr_data [n_out];
	logic        [n_out-1:0]          opp_valid;
	logic        [pid_pkg::w_dac-1:0] opp_data [n_out];

	////////////////////////////////////////////////////////////
	// per input channel, filter then pid
	////////////////////////////////////////////////////////////

	for (genvar g = 0; g < n_in; g++) begin : ch_gen
		assign smp_valid[g] = sample_valid && (sample_chan == w_in_ch'(g));

		oversample_filter u_osf (
			.clk50      (clk50),
			.rst_n      (rst_n),
			.in_valid   (smp_valid[g]),
			.in_data    (sample_data),	// shared bus, strobe selects
			.osm        (osm),
			.cfg_update (cfg_update),
			.out_valid  (osf_valid[g]),
			.out_data   (osf_data[g])
		);

		pid_core u_pid (
			.clk50     (clk50),
			.rst_n     (rst_n),
			.in_valid  (osf_valid[g]),
			.in_data   (osf_data[g]),
			.setpoint  (setpoint),
			.p_coef    (p_coef),
			.i_coef    (i_coef),
			.d_coef    (d_coef),
			.clear     (cfg_update),	// new gains start from a clean integrator
			.out_valid (pid_valid[g]),
			.out_data  (pid_data[g])
		);
	end

	////////////////////////////////////////////////////////////
	// routing, scaling and dac queue
	////////////////////////////////////////////////////////////

	router #(
		.n_in  (n_in),
		.n_out (n_out)
	) u_rtr (
		.clk50      (clk50),
		.rst_n      (rst_n),
		.in_valid   (pid_valid),
		.in_data    (pid_data),
		.sel        (rtr_sel),
		.cfg_update (cfg_update),
		.out_valid  (rtr_valid),
		.out_data   (rtr_data)
	);

	for (genvar g = 0; g < n_out; g++) begin : out_gen
		output_preprocessor u_opp (
			.clk50      (clk50),
			.rst_n      (rst_n),
			.in_valid   (rtr_valid[g]),
			.in_data    (rtr_data[g]),
			.lock_en    (lock_en[g]),
			.out_min    (out_min),
			.out_max    (out_max),
			.out_init   (out_init),
			.multiplier (multiplier),
			.out_valid  (opp_valid[g]),
			.out_data   (opp_data[g])
		);
	end

	dac_instr_queue #(
		.n_out (n_out)
	) u_diq (
		.clk50     (clk50),
		.rst_n     (rst_n),
		.in_valid  (opp_valid),
		.in_data   (opp_data),
		.dac_valid (dac_valid),
		.dac_ready (dac_ready),
		.dac_chan  (dac_chan),
		.dac_data  (dac_data)
	);

endmodule

`default_nettype wire

//--- rtl/pid_core.sv
`timescale 1ns/1ps
`default_nettype none

module pid_core (
	input  logic                              clk50,
	input  logic                              rst_n,
	input  logic                              in_valid,
	input  logic signed [pid_pkg::w_pid-1:0]  in_data,	// averaged error signal
	input  logic signed [pid_pkg::w_coef-1:0] setpoint,
	input  logic signed [pid_pkg::w_coef-1:0] p_coef,
	input  logic signed [pid_pkg::w_coef-1:0] i_coef,
	input  logic signed [pid_pkg::w_coef-1:0] d_coef,
	input  logic                              clear,		// zero integrator and last error
	output logic                              out_valid,
	output logic signed [pid_pkg::w_pid-1:0]  out_data
);

	localparam int w_acc = pid_pkg::w_acc;
	localparam int w_err = pid_pkg::w_pid + 1;	// setpoint - input grows one bit
	localparam int w_dif = w_err + 1;
	localparam logic signed [w_acc-1:0] sat_hi = w_acc'(2**(pid_pkg::w_pid-1) - 1);
	localparam logic signed [w_acc-1:0] sat_lo = w_acc'(-(2**(pid_pkg::w_pid-1)));

	logic signed [w_err-1:0] err;
	logic signed [w_dif-1:0] dif;
	logic signed [w_err-1:0] prev_err;	// error of the previous sample
	logic signed [w_acc-1:0] integ;		// running sum of errors, wraps
	logic signed [w_err-1:0] err_q;
	logic signed [w_dif-1:0] dif_q;
	logic                    v1;		// stage 1 holds a sample
	logic signed [w_acc-1:0] pid_sum;
	logic signed [w_acc-1:0] pid_shr;

	////////////////////////////////////////////////////////////
	// stage 1 forms error, delta and integrator
	////////////////////////////////////////////////////////////

	always_comb begin
		err = w_err'(setpoint) - w_err'(in_data);
		dif = w_dif'(err) - w_dif'(prev_err);
	end

	always_ff @(posedge clk50 or negedge rst_n) begin
		if (!rst_n) begin
			integ    <= '0;
			prev_err <= '0;
			v1       <= 1'b0;
		end else begin
			v1 <= in_valid;
			if (clear) begin
				integ    <= '0;
				prev_err <= '0;
			end else if (in_valid) begin
				integ    <= integ + w_acc'(err);
				prev_err <= err;
			end
		end
	end

	always_ff @(posedge clk50) begin
		if (in_valid) begin
			err_q <= err;
			dif_q <= dif;
		end
	end

	////////////////////////////////////////////////////////////
	// stage 2 weights, scales and clips
	////////////////////////////////////////////////////////////

	always_comb begin
		// all terms evaluated at accumulator width
		pid_sum = w_acc'(p_coef) * w_acc'(err_q)
			+ w_acc'(i_coef) * integ
			+ w_acc'(d_coef) * w_acc'(dif_q);
		pid_shr = pid_sum >>> pid_pkg::coef_shift;	// drop gain fraction bits
	end

	always_ff @(posedge clk50 or negedge rst_n) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= v1;
	end

	always_ff @(posedge clk50) begin
		if (v1) begin
			if (pid_shr > sat_hi)
				out_data <= sat_hi[pid_pkg::w_pid-1:0];
			else if (pid_shr < sat_lo)
				out_data <= sat_lo[pid_pkg::w_pid-1:0];
			else
				out_data <= pid_shr[pid_pkg::w_pid-1:0];
		end
	end

endmodule

`default_nettype wire

//--- rtl/pid_pkg.sv
`default_nettype none

package pid_pkg;

	////////////////////////////////////////////////////////////
	// data path widths
	////////////////////////////////////////////////////////////

	localparam int w_sample   = 18;	// adc word, two's complement
	localparam int w_pid      = 18;	// osf and pid result, signed
	localparam int w_dac      = 16;	// dac code, straight binary
	localparam int w_osm      = 3;	// oversample mode, 0..4 in use

	////////////////////////////////////////////////////////////
	// fixed point
	////////////////////////////////////////////////////////////

	// gains are q7.8, the pid sum drops the fraction afterwards
	localparam int w_coef     = 16;	// setpoint and p/i/d gains, signed
	localparam int coef_shift = 8;	// fraction bits of the gains
	localparam int w_acc      = 40;	// integrator and pid sum
	localparam int w_mult     = 8;	// output gain, unsigned

endpackage

`default_nettype wire

//--- rtl/router.sv
`timescale 1ns/1ps
`default_nettype none

// n_in is at least 2 so the select field has a bit
module router #(
	parameter int n_in  = 4,	// pid channels
	parameter int n_out = 4	// dac channels
) (
	input  logic                             clk50,
	input  logic                             rst_n,
	input  logic        [n_in-1:0]           in_valid,
	input  logic signed [pid_pkg::w_pid-1:0] in_data [n_in],
	input  logic        [$clog2(n_in)-1:0]   sel [n_out],	// source index per output
	input  logic                             cfg_update,
	output logic        [n_out-1:0]          out_valid,
	output logic signed [pid_pkg::w_pid-1:0] out_data [n_out]
);

	logic [$clog2(n_in)-1:0] sel_q [n_out];	// table in force

	always_ff @(posedge clk50 or negedge rst_n) begin
		if (!rst_n) begin
			sel_q     <= '{default: '0};	// every output listens to pid 0
			out_valid <= '0;
		end else begin
			if (cfg_update)
				sel_q <= sel;
			for (int o = 0; o < n_out; o++)
				out_valid[o] <= in_valid[sel_q[o]];	// fan out, one source may feed many
		end
	end

	always_ff @(posedge clk50) begin
		for (int o = 0; o < n_out; o++)
			out_data[o] <= in_data[sel_q[o]];
	end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only on the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps --top-module tb_pid_controller \
	-f list.f -o sim_pid_controller

./obj_dir/sim_pid_controller | tee sim.log

grep -q "^Simulation completed successfully$" sim.log

//--- tests/dac_checker.sv
`timescale 1ns/1ps
`default_nettype none

// watches the dac port and matches every transfer against the model
module dac_checker #(
	parameter int n_out = 4
) (
	input  logic                         clk50,
	input  logic                         rst_n,
	input  logic                         dac_valid,
	input  logic                         dac_ready,
	input  logic [$clog2(n_out)-1:0]     dac_chan,
	input  logic [pid_pkg::w_dac-1:0]    dac_data
);

	logic [pid_pkg::w_dac-1:0] exp_q [n_out][$];	// model values per channel, oldest first
	logic [pid_pkg::w_dac-1:0] last_got [n_out];	// newest value seen per channel
	logic [pid_pkg::w_dac-1:0] last_exp [n_out];	// newest model value per channel
	bit                        pushed [n_out];	// model produced a value since the last drain
	bit                        seen [n_out];		// a transfer happened since the last drain
	bit                        strict_order = 1'b0;	// every model value must come out
	int                        n_checked = 0;
	int                        n_errors = 0;

	task push_expected(input int ch, input logic [pid_pkg::w_dac-1:0] v);
		exp_q[ch].push_back(v);
		last_exp[ch] = v;
		pushed[ch] = 1'b1;
	endtask

	task set_strict(input bit s);
		strict_order = s;
	endtask

	// after a drain the newest model value must have been the last one out
	task check_drained();
		for (int c = 0; c < n_out; c++) begin
			if (pushed[c] && (!seen[c] || last_got[c] != last_exp[c])) begin
				$display("error dac_data chan %0h: final value %h never sent, last got %h",
					c, last_exp[c], last_got[c]);
				n_errors++;
			end else if (strict_order && exp_q[c].size() != 0) begin
				$display("error dac_data chan %0h: %0h model values never sent, first %h",
					c, exp_q[c].size(), exp_q[c][0]);
				n_errors++;
			end
			exp_q[c].delete();
			pushed[c] = 1'b0;
			seen[c] = 1'b0;
		end
	endtask

	////////////////////////////////////////////////////////////
	// transfer check, port is stable at the falling edge
	////////////////////////////////////////////////////////////

	always @(negedge clk50) begin
		int ch;
		int hit;
		if (rst_n && dac_valid && dac_ready) begin
			ch = int'(dac_chan);
			hit = -1;
			n_checked++;
			last_got[ch] = dac_data;
			seen[ch] = 1'b1;
			for (int j = 0; j < exp_q[ch].size(); j++)
				if (hit < 0 && exp_q[ch][j] == dac_data)
					hit = j;	// earliest match keeps the order
			if (hit < 0) begin
				if (exp_q[ch].size() == 0)
					$display("error dac_data chan %0h: got %h, nothing expected", ch, dac_data);
				else
					$display("error dac_data chan %0h: got %h, expected %h or later",
						ch, dac_data, exp_q[ch][0]);
				n_errors++;
			end else begin
				if (strict_order && hit > 0) begin
					$display("error dac_data chan %0h: got %h, expected %h first",
						ch, dac_data, exp_q[ch][0]);
					n_errors++;
				end
				repeat (hit + 1)
					void'(exp_q[ch].pop_front());	// skipped values were overwritten
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_pid_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pid_controller;

	localparam int n_in      = 4;
	localparam int n_out     = 4;
	localparam int w_ich     = $clog2(n_in);
	localparam int n_smp     = 64;				// samples per phase
	localparam int wd_cycles = 7 * n_smp * 4 + 2000;	// seven phases

	logic                              clk50;
	logic                              rst_n;
	logic                              sample_valid;
	logic        [w_ich-1:0]           sample_chan;
	logic signed [pid_pkg::w_sample-1:0] sample_data;
	logic                              cfg_update;
	logic        [pid_pkg::w_osm-1:0]  osm;
	logic signed [pid_pkg::w_coef-1:0] setpoint;
	logic signed [pid_pkg::w_coef-1:0] p_coef;
	logic signed [pid_pkg::w_coef-1:0] i_coef;
	logic signed [pid_pkg::w_coef-1:0] d_coef;
	logic        [w_ich-1:0]           rtr_sel [n_out];
	logic        [n_out-1:0]           lock_en;
	logic        [pid_pkg::w_dac-1:0]  out_min;
	logic        [pid_pkg::w_dac-1:0]  out_max;
	logic        [pid_pkg::w_dac-1:0]  out_init;
	logic        [pid_pkg::w_mult-1:0] multiplier;
	logic                              dac_valid;
	logic                              dac_ready;
	logic        [$clog2(n_out)-1:0]   dac_chan;
	logic        [pid_pkg::w_dac-1:0]  dac_data;

	logic [31:0] lfsr;		// stimulus state
	bit          ready_random;	// dac_ready from the lfsr, else held high
	int          tb_errors;
	longint      osf_sum [n_in];	// model state per channel
	int          osf_cnt [n_in];
	longint      integ [n_in];
	longint      prev_err [n_in];
	int          m_osm;
	int          m_sel [n_out];

	pid_controller #(.n_in(n_in), .n_out(n_out)) u_dut (.*);

	dac_checker #(.n_out(n_out)) u_chk (
		.clk50     (clk50),
		.rst_n     (rst_n),
		.dac_valid (dac_valid),
		.dac_ready (dac_ready),
		.dac_chan  (dac_chan),
		.dac_data  (dac_data)
	);

	initial begin
		clk50 = 1'b0;
		forever #20 clk50 = ~clk50;	// 25 MHz sim clock, 40 ns
	end

	////////////////////////////////////////////////////////////
	// random source and reference model
	////////////////////////////////////////////////////////////

	// fibonacci, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic longint rand_signed(input int n);
		longint v;
		v = 0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);	// one step per bit
			v = (v << 1) | longint'(lfsr[0]);
		end
		return (v <<< (64 - n)) >>> (64 - n);	// sign extend from bit n-1
	endfunction

	function automatic logic signed [pid_pkg::w_coef-1:0] rand_coef(input int n);
		longint v;
		v = rand_signed(n) | 1;	// odd, never zero
		return v[pid_pkg::w_coef-1:0];
	endfunction

	function automatic longint wrap_acc(input longint v);
		return (v <<< (64 - pid_pkg::w_acc)) >>> (64 - pid_pkg::w_acc);
	endfunction

	function automatic longint sat_pid(input longint v);
		longint lim;
		lim = longint'(1) <<< (pid_pkg::w_pid - 1);
		if (v > lim - 1)
			return lim - 1;
		if (v < -lim)
			return -lim;
		return v;
	endfunction

	// dac code for one pid word, offset then clamp
	function automatic logic [pid_pkg::w_dac-1:0] scale_out(input longint pid, input logic lock);
		longint s;
		s = longint'(out_init) + pid * longint'(multiplier);
		if (!lock)
			return out_init;	// hold value
		if (s < longint'(out_min))
			return out_min;
		if (s > longint'(out_max))
			return out_max;
		return s[pid_pkg::w_dac-1:0];
	endfunction

	task model_sample(input int ch, input longint x);
		longint avg;
		longint err;
		longint dif;
		longint pid;
		osf_sum[ch] += x;
		osf_cnt[ch]++;
		if (osf_cnt[ch] == (1 << m_osm)) begin
			avg = sat_pid(osf_sum[ch] >>> m_osm);
			osf_sum[ch] = 0;
			osf_cnt[ch] = 0;
			err = longint'(setpoint) - avg;
			dif = err - prev_err[ch];
			prev_err[ch] = err;
			integ[ch] = wrap_acc(integ[ch] + err);	// new integrator feeds this sum
			pid = sat_pid(wrap_acc(longint'(p_coef) * err + longint'(i_coef) * integ[ch]
				+ longint'(d_coef) * dif) >>> pid_pkg::coef_shift);
			for (int o = 0; o < n_out; o++)
				if (m_sel[o] == ch)
					u_chk.push_expected(o, scale_out(pid, lock_en[o]));
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	task tick();
		@(posedge clk50);
		dac_ready <= ready_random ? (rand_signed(1) != 0) : 1'b1;
	endtask

	task send_sample(input int ch, input longint x);
		tick();
		sample_valid <= 1'b1;
		sample_chan  <= w_ich'(ch);
		sample_data  <= x[pid_pkg::w_sample-1:0];
		model_sample(ch, x);
	endtask

	task apply_cfg(input logic [pid_pkg::w_osm-1:0] o,
		input logic signed [pid_pkg::w_coef-1:0] sp, kp, ki, kd,
		input logic [n_out*w_ich-1:0] sel, input logic [n_out-1:0] lock,
		input logic [pid_pkg::w_dac-1:0] mn, mx, init, input logic [pid_pkg::w_mult-1:0] mult);
		tick();
		osm        <= o;
		setpoint   <= sp;
		p_coef     <= kp;
		i_coef     <= ki;
		d_coef     <= kd;
		lock_en    <= lock;
		out_min    <= mn;
		out_max    <= mx;
		out_init   <= init;
		multiplier <= mult;
		cfg_update <= 1'b1;
		for (int k = 0; k < n_out; k++) begin
			rtr_sel[k] <= sel[k*w_ich +: w_ich];
			m_sel[k] = int'(sel[k*w_ich +: w_ich]);
		end
		for (int c = 0; c < n_in; c++) begin
			osf_sum[c] = 0;	// partial groups and pid state dropped
			osf_cnt[c] = 0;
			integ[c] = 0;
			prev_err[c] = 0;
		end
		m_osm = int'(o);
		tick();
		cfg_update <= 1'b0;
	endtask

	// ready high until the dac port has been quiet for a while
	task drain();
		int quiet;
		ready_random = 1'b0;
		quiet = 0;
		tick();
		sample_valid <= 1'b0;
		while (quiet < 16) begin
			tick();
			quiet = dac_valid ? 0 : quiet + 1;
		end
		u_chk.check_drained();
	endtask

	task run_phase(input int n, input int bits, input bit rand_chan);
		int ch;
		for (int i = 0; i < n; i++) begin
			ch = rand_chan ? (int'(rand_signed(w_ich)) & (n_in - 1)) : (i % n_in);
			send_sample(ch, rand_signed(bits));
		end
		drain();
	endtask

	initial begin
		logic signed [pid_pkg::w_coef-1:0] sp;
		logic signed [pid_pkg::w_coef-1:0] kp;
		logic signed [pid_pkg::w_coef-1:0] ki;
		logic signed [pid_pkg::w_coef-1:0] kd;
		lfsr = 32'h9ab63df0;
		tb_errors = 0;
		ready_random = 1'b0;
		rst_n = 1'b0;
		sample_valid = 1'b0;
		sample_chan = '0;
		sample_data = '0;
		cfg_update = 1'b0;
		osm = '0;
		setpoint = '0;
		p_coef = '0;
		i_coef = '0;
		d_coef = '0;
		rtr_sel = '{default: '0};
		lock_en = '0;
		out_min = '0;
		out_max = '0;
		out_init = '0;
		multiplier = '0;
		dac_ready = 1'b1;
		repeat (3) @(posedge clk50);
		rst_n <= 1'b1;

		// idle after reset, the dac port must stay quiet
		repeat (20) begin
			tick();
			if (dac_valid) begin
				$display("dac_valid went high after reset although no sample was sent");
				tb_errors++;
			end
		end

		// groups of 4, unity p, identity routing, nothing may be skipped
		apply_cfg(3'd2, 16'sd0, 16'sd256, 16'sd0, 16'sd0, 8'he4, 4'hf,
			16'h0000, 16'hffff, 16'h8000, 8'd1);
		u_chk.set_strict(1'b1);
		run_phase(n_smp, 14, 1'b0);
		u_chk.set_strict(1'b0);

		// random gains twice, second run starts from a cleared integrator
		repeat (2) begin
			sp = rand_coef(12);
			kp = rand_coef(9);
			ki = rand_coef(6);
			kd = rand_coef(8);
			apply_cfg(3'd1, sp, kp, ki, kd, 8'he4, 4'hf, 16'h0000, 16'hffff, 16'h8000, 8'd3);
			run_phase(n_smp, 12, 1'b1);
		end

		// outputs 1 and 2 share pid 1, output 3 parked on out_init
		apply_cfg(3'd0, sp, kp, ki, kd, 8'b10_01_01_00, 4'b0111,
			16'h0000, 16'hffff, 16'h8000, 8'd2);
		run_phase(n_smp, 12, 1'b1);

		// large gain, values pinned to the clamp limits
		apply_cfg(3'd1, 16'sd0, 16'sh7fff, 16'sd0, 16'sd0, 8'he4, 4'hf,
			16'h1000, 16'hf000, 16'h8000, 8'hff);
		run_phase(n_smp, 18, 1'b1);

		// back-pressure from a random dac_ready
		apply_cfg(3'd0, sp, kp, ki, kd, 8'he4, 4'hf, 16'h0000, 16'hffff, 16'h8000, 8'd2);
		ready_random = 1'b1;
		run_phase(2 * n_smp, 12, 1'b1);

		$display("dac checks %0d, value errors %0d, other errors %0d",
			u_chk.n_checked, u_chk.n_errors, tb_errors);
		if (u_chk.n_errors + tb_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// watchdog, sized from the sample count
	initial begin
		repeat (wd_cycles) @(posedge clk50);
		$display("timeout: the run did not finish within %0d cycles", wd_cycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
